//--- verilog/bmd_tlp_pkg.sv
// Link-side types; TAG_W_DEF must stay 2..8 and TIME_W_DEF at least 32 bits
package bmd_tlp_pkg;

  //////////////////////////////
  // Default widths
  //////////////////////////////

  // One tag per outstanding read
  localparam int TAG_W_DEF = 5;

  // Headroom for very long runs
  localparam int TIME_W_DEF = 38;

  //////////////////////////////
  // Request types
  //////////////////////////////

  typedef enum logic [0:0] {
    TLP_MWR = 1'b0,  // Memory write
    TLP_MRD = 1'b1   // Memory read
  } tlp_op_e;

  // Byte address for 32-bit addressing only
  typedef logic [31:0] dma_addr_t;

  // Payload in dwords to fit the 10-bit TLP length field
  typedef logic [9:0] dw_len_t;

endpackage : bmd_tlp_pkg

//--- verilog/bmd_ctrl_pkg.sv
// Host register map and sequencer states; unmapped addresses 5..7 read as zero
package bmd_ctrl_pkg;

  //////////////////////////////
  // Register map
  //////////////////////////////

  typedef enum logic [2:0] {
    REG_DMA_ADDR  = 3'd0,  // RW, DMA base byte address
    REG_DW_COUNT  = 3'd1,  // RW, payload dwords per TLP
    REG_TLP_COUNT = 3'd2,  // RW, TLPs per direction
    REG_CPL_COUNT = 3'd3,  // RO, completions seen
    REG_LAT_MAX   = 3'd4   // RO, low word of max latency
  } reg_addr_e;

  // Host data word
  typedef logic [31:0] reg_data_t;

  //////////////////////////////
  // Sequencer FSM
  //////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE  = 2'd0,  // Nothing on offer
    SEQ_WRITE = 2'd1,  // Memory writes
    SEQ_READ  = 2'd2   // Memory reads, one tag each
  } seq_state_e;

endpackage : bmd_ctrl_pkg

//--- verilog/bmd_cmd_if.sv
// Run command bundle; init, start and stop are single-cycle pulses from the decoder
`timescale 1ns/1ps

interface bmd_cmd_if #(
  parameter int TAG_W = bmd_tlp_pkg::TAG_W_DEF
);

  import bmd_tlp_pkg::*;

  //////////////////////////////
  // Run control
  //////////////////////////////

  logic             init;       // Clears run state
  logic             start;      // Launches the writes
  logic             stop;       // Ends the run early

  //////////////////////////////
  // Run setup
  //////////////////////////////

  dma_addr_t        dma_addr;   // Base byte address
  dw_len_t          dw_count;   // Dwords per TLP
  logic [TAG_W:0]   tlp_count;  // Up to 2**TAG_W

  // Register side
  modport decode (
    output init, start, stop, dma_addr, dw_count, tlp_count
  );

  // Request side
  modport seq (
    input  init, start, stop, dma_addr, dw_count, tlp_count
  );

  // Statistics side, only needs the clear and the target count
  modport result (
    input  init, tlp_count
  );

endinterface : bmd_cmd_if

//--- verilog/bmd_req_decode.sv
// Host writes land on the sampling edge, reads answer one cycle later; tlp_count is TAG_W+1 bits
`timescale 1ns/1ps

module bmd_req_decode #(
  parameter int TAG_W  = bmd_tlp_pkg::TAG_W_DEF,
  parameter int TIME_W = bmd_tlp_pkg::TIME_W_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cq_valid_i,    // Request strobe
  input  logic                    cq_write_i,    // 1 write, 0 read
  input  bmd_ctrl_pkg::reg_addr_e cq_addr_i,
  input  bmd_ctrl_pkg::reg_data_t cq_data_i,
  output logic                    cc_valid_o,    // One-cycle response
  output bmd_ctrl_pkg::reg_data_t cc_data_o,
  input  logic                    run_start_i,   // Level, rising edge starts
  input  logic                    run_finish_i,  // Pulse
  input  logic [TAG_W:0]          cpl_count_i,
  input  logic [TIME_W-1:0]       lat_max_i,
  bmd_cmd_if.decode               cmd
);

  import bmd_ctrl_pkg::*;

  logic      start_d;    // Previous run_start_i
  logic      finish_d;   // Previous run_finish_i
  reg_data_t rd_mux;     // Read data before the flop

  //////////////////////////////
  // Control registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd.dma_addr  <= '0;
      cmd.dw_count  <= '0;
      cmd.tlp_count <= '0;
    end else if (cq_valid_i && cq_write_i) begin
      case (cq_addr_i)
        REG_DMA_ADDR:  cmd.dma_addr  <= cq_data_i;
        REG_DW_COUNT:  cmd.dw_count  <= cq_data_i[9:0];
        REG_TLP_COUNT: cmd.tlp_count <= cq_data_i[TAG_W:0];
        default:       ;  // Read-only or unmapped
      endcase
    end
  end

  always_comb begin
    case (cq_addr_i)
      REG_DMA_ADDR:  rd_mux = cmd.dma_addr;
      REG_DW_COUNT:  rd_mux = reg_data_t'(cmd.dw_count);
      REG_TLP_COUNT: rd_mux = reg_data_t'(cmd.tlp_count);
      REG_CPL_COUNT: rd_mux = reg_data_t'(cpl_count_i);
      REG_LAT_MAX:   rd_mux = lat_max_i[31:0];  // Low word only
      default:       rd_mux = '0;
    endcase
  end

  // Response strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) cc_valid_o <= 1'b0;
    else        cc_valid_o <= cq_valid_i && !cq_write_i;
  end

  // Response data, only meaningful with cc_valid_o
  always_ff @(posedge clk) begin
    if (cq_valid_i && !cq_write_i) cc_data_o <= rd_mux;
  end

  //////////////////////////////
  // Run control
  //////////////////////////////

  // Start edge gives init, init gives start one cycle on
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_d   <= 1'b0;
      finish_d  <= 1'b0;
      cmd.init  <= 1'b0;
      cmd.start <= 1'b0;
    end else begin
      start_d   <= run_start_i;
      finish_d  <= run_finish_i;
      cmd.init  <= run_start_i && !start_d;  // Rising edge only
      cmd.start <= cmd.init;
    end
  end

  // Same cycle as the pulse so the offer in flight is the last one
  assign cmd.stop = run_finish_i && !finish_d;

endmodule : bmd_req_decode

//--- verilog/bmd_tx_sequencer.sv
// Issues N writes then N reads, tag = index; N is latched at start and must be 1..2**TAG_W
`timescale 1ns/1ps

module bmd_tx_sequencer #(
  parameter int TAG_W = bmd_tlp_pkg::TAG_W_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  bmd_cmd_if.seq                  cmd,
  output logic                    rq_valid_o,
  input  logic                    rq_ready_i,
  output bmd_tlp_pkg::tlp_op_e    rq_opcode_o,
  output bmd_tlp_pkg::dma_addr_t  rq_addr_o,
  output bmd_tlp_pkg::dw_len_t    rq_len_o,
  output logic [TAG_W-1:0]        rq_tag_o,
  output logic                    stamp_we_o,   // Read handshake this edge
  output logic [TAG_W-1:0]        stamp_tag_o
);

  import bmd_tlp_pkg::*;
  import bmd_ctrl_pkg::*;

  seq_state_e     state;
  logic           stop_pend;   // Finish seen while an offer waits
  dma_addr_t      base_q;      // Base for the read pass
  logic [TAG_W:0] cnt_q;       // TLPs per direction
  dma_addr_t      step_bytes;  // Payload size in bytes
  logic           launch;
  logic           hs;
  logic           last;

  assign launch     = cmd.start && (cmd.tlp_count != '0);
  assign hs         = rq_valid_o && rq_ready_i;             // Transfer this edge
  assign last       = ({1'b0, rq_tag_o} + 1'b1) == cnt_q;   // Final index of the pass
  assign step_bytes = dma_addr_t'({rq_len_o, 2'b00});

  // Something is on offer in every non-idle state
  assign rq_valid_o = (state != SEQ_IDLE);

  // Timestamp at the same edge as the read handshake
  assign stamp_we_o  = hs && (state == SEQ_READ);
  assign stamp_tag_o = rq_tag_o;

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= SEQ_IDLE;
      stop_pend <= 1'b0;
    end else if (cmd.init) begin
      state     <= SEQ_IDLE;   // New run, drop everything
      stop_pend <= 1'b0;
    end else if (launch) begin
      state     <= SEQ_WRITE;
      stop_pend <= 1'b0;
    end else if (hs) begin
      if (stop_pend || cmd.stop || (state == SEQ_READ && last)) begin
        state     <= SEQ_IDLE;  // Run over
        stop_pend <= 1'b0;
      end else if (last) begin
        state <= SEQ_READ;      // Writes done, turn around
      end
    end else if (cmd.stop) begin
      stop_pend <= rq_valid_o;  // Finish the held offer first
    end
  end

  //////////////////////////////
  // Request fields
  //////////////////////////////

  // Held while valid and not ready, so back-pressure keeps them stable
  always_ff @(posedge clk) begin
    if (launch) begin
      base_q      <= cmd.dma_addr;
      cnt_q       <= cmd.tlp_count;
      rq_opcode_o <= TLP_MWR;
      rq_addr_o   <= cmd.dma_addr;
      rq_len_o    <= cmd.dw_count;
      rq_tag_o    <= '0;
    end else if (hs) begin
      if (last) begin
        rq_opcode_o <= TLP_MRD;  // Read pass restarts at the base
        rq_addr_o   <= base_q;
        rq_tag_o    <= '0;
      end else begin
        rq_addr_o <= rq_addr_o + step_bytes;
        rq_tag_o  <= rq_tag_o + 1'b1;
      end
    end
  end

endmodule : bmd_tx_sequencer

//--- verilog/bmd_cpl_latency.sv
// Round-trip latency per tag in clk cycles; a tag must not be reused before its completion
`timescale 1ns/1ps

module bmd_cpl_latency #(
  parameter int TAG_W  = bmd_tlp_pkg::TAG_W_DEF,
  parameter int TIME_W = bmd_tlp_pkg::TIME_W_DEF
) (
  input  logic              clk,
  input  logic              rst_n,
  bmd_cmd_if.result         cmd,
  input  logic              stamp_we_i,   // Read handshake edge
  input  logic [TAG_W-1:0]  stamp_tag_i,
  input  logic              rc_valid_i,   // Completion strobe
  input  logic [TAG_W-1:0]  rc_tag_i,
  output logic [TAG_W:0]    cpl_count_o,
  output logic [TIME_W-1:0] lat_max_o,
  output logic              run_done_o    // Sticky until next init
);

  logic [TIME_W-1:0] time_q;                  // Free-running time base
  logic [TIME_W-1:0] stamp_mem [2**TAG_W];    // Issue time per tag
  logic [TIME_W-1:0] lat;

  // Edges since the handshake, completion edge included
  assign lat = time_q - stamp_mem[rc_tag_i];

  //////////////////////////////
  // Time base and stamps
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)        time_q <= '0;
    else if (cmd.init) time_q <= '0;
    else               time_q <= time_q + 1'b1;
  end

  always_ff @(posedge clk) begin
    if (stamp_we_i) stamp_mem[stamp_tag_i] <= time_q;
  end

  //////////////////////////////
  // Statistics
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cpl_count_o <= '0;
      lat_max_o   <= '0;
      run_done_o  <= 1'b0;
    end else if (cmd.init) begin
      cpl_count_o <= '0;   // Fresh run
      lat_max_o   <= '0;
      run_done_o  <= 1'b0;
    end else if (rc_valid_i) begin
      cpl_count_o <= cpl_count_o + 1'b1;
      if (lat > lat_max_o) lat_max_o <= lat;
      if (cpl_count_o + 1'b1 == cmd.tlp_count) run_done_o <= 1'b1;  // Last one back
    end
  end

endmodule : bmd_cpl_latency

//--- verilog/bmd_endpoint.sv
// Bus-master endpoint top; TAG_W 2..8, TIME_W >= 32, lat_max low word also readable by the host
`timescale 1ns/1ps

module bmd_endpoint #(
  parameter int TAG_W  = bmd_tlp_pkg::TAG_W_DEF,
  parameter int TIME_W = bmd_tlp_pkg::TIME_W_DEF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  // Completer request and response
  input  logic                    cq_valid_i,
  input  logic                    cq_write_i,
  input  bmd_ctrl_pkg::reg_addr_e cq_addr_i,
  input  bmd_ctrl_pkg::reg_data_t cq_data_i,
  output logic                    cc_valid_o,
  output bmd_ctrl_pkg::reg_data_t cc_data_o,
  // Requests out
  output logic                    rq_valid_o,
  input  logic                    rq_ready_i,
  output bmd_tlp_pkg::tlp_op_e    rq_opcode_o,
  output bmd_tlp_pkg::dma_addr_t  rq_addr_o,
  output bmd_tlp_pkg::dw_len_t    rq_len_o,
  output logic [TAG_W-1:0]        rq_tag_o,
  // Requester completions
  input  logic                    rc_valid_i,
  input  logic [TAG_W-1:0]        rc_tag_i,
  // Run control and status
  input  logic                    run_start_i,
  input  logic                    run_finish_i,
  output logic [TAG_W:0]          cpl_count_o,
  output logic [TIME_W-1:0]       lat_max_o,
  output logic                    run_done_o
);

  logic             stamp_we;
  logic [TAG_W-1:0] stamp_tag;

  bmd_cmd_if #(.TAG_W(TAG_W)) cmd_if ();

  bmd_req_decode #(.TAG_W(TAG_W), .TIME_W(TIME_W)) u_decode (
    .clk, .rst_n, .cq_valid_i, .cq_write_i, .cq_addr_i, .cq_data_i,
    .cc_valid_o, .cc_data_o, .run_start_i, .run_finish_i,
    .cpl_count_i (cpl_count_o),
    .lat_max_i   (lat_max_o),
    .cmd         (cmd_if.decode)
  );

  bmd_tx_sequencer #(.TAG_W(TAG_W)) u_seq (
    .clk, .rst_n,
    .cmd         (cmd_if.seq),
    .rq_valid_o, .rq_ready_i, .rq_opcode_o, .rq_addr_o, .rq_len_o, .rq_tag_o,
    .stamp_we_o  (stamp_we),
    .stamp_tag_o (stamp_tag)
  );

  bmd_cpl_latency #(.TAG_W(TAG_W), .TIME_W(TIME_W)) u_lat (
    .clk, .rst_n,
    .cmd         (cmd_if.result),
    .stamp_we_i  (stamp_we),
    .stamp_tag_i (stamp_tag),
    .rc_valid_i, .rc_tag_i, .cpl_count_o, .lat_max_o, .run_done_o
  );

endmodule : bmd_endpoint

//--- testbench/tb_bmd_checks.svh
// Included inside tb_bmd_endpoint after err_cnt, chk_cnt, tag_t and lat_t are declared
`ifndef TB_BMD_CHECKS_SVH
`define TB_BMD_CHECKS_SVH

// Address of request i, same for writes and reads
function automatic dma_addr_t ref_req_addr(input dma_addr_t base, input dw_len_t dw, input int i);
  return base + dma_addr_t'(i) * dma_addr_t'(dw) * 32'd4;  // dw dwords of 4 bytes each
endfunction

task automatic check_reg(input string name, input reg_data_t got, input reg_data_t exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("error t=%0t %s got %h exp %h", $time, name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_req(input tlp_op_e got_op, input tlp_op_e exp_op,
                         input dma_addr_t got_addr, input dma_addr_t exp_addr,
                         input dw_len_t got_len, input dw_len_t exp_len,
                         input tag_t got_tag, input tag_t exp_tag, input bit with_tag);
  chk_cnt++;
  if (got_op !== exp_op) begin
    $display("error t=%0t rq_opcode_o got %s exp %s", $time, got_op.name(), exp_op.name());
    err_cnt++;
  end
  if (got_addr !== exp_addr) begin
    $display("error t=%0t rq_addr_o got %h exp %h", $time, got_addr, exp_addr);
    err_cnt++;
  end
  if (got_len !== exp_len) begin
    $display("error t=%0t rq_len_o got %0d exp %0d", $time, got_len, exp_len);
    err_cnt++;
  end
  if (with_tag && got_tag !== exp_tag) begin  // Tags only matter on reads
    $display("error t=%0t rq_tag_o got %0d exp %0d", $time, got_tag, exp_tag);
    err_cnt++;
  end
endtask

task automatic check_lat(input string name, input lat_t got, input lat_t exp);
  chk_cnt++;
  if (got !== exp) begin
    $display("error t=%0t %s got %0d exp %0d", $time, name, got, exp);
    err_cnt++;
  end
endtask

`endif

//--- testbench/tb_bmd_endpoint.sv
// Random ready and completion delays come from seed 32'h78c8; at most 2**TAG_W TLPs per run
`timescale 1ns/1ps

module tb_bmd_endpoint;

  import bmd_tlp_pkg::*;
  import bmd_ctrl_pkg::*;

  localparam int TAG_W     = TAG_W_DEF;
  localparam int TIME_W    = TIME_W_DEF;
  localparam int N_ORDER   = 8;
  localparam int N_BP      = 32;   // Every tag in use
  localparam int N_ABORT   = 16;
  localparam int N_RESTART = 16;
  localparam int WATCHDOG_CYC = (N_ORDER + N_BP + N_ABORT + N_RESTART) * 40 + 2000;

  typedef logic [TAG_W-1:0]  tag_t;
  typedef logic [TIME_W-1:0] lat_t;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic        cq_valid_i = 1'b0;
  logic        cq_write_i = 1'b0;
  reg_addr_e   cq_addr_i = REG_DMA_ADDR;
  reg_data_t   cq_data_i = '0;
  logic        cc_valid_o;
  reg_data_t   cc_data_o;
  logic        rq_valid_o;
  logic        rq_ready_i = 1'b0;
  tlp_op_e     rq_opcode_o;
  dma_addr_t   rq_addr_o;
  dw_len_t     rq_len_o;
  tag_t        rq_tag_o;
  logic        rc_valid_i = 1'b0;
  tag_t        rc_tag_i = '0;
  logic        run_start_i = 1'b0;
  logic        run_finish_i = 1'b0;
  logic [TAG_W:0] cpl_count_o;
  lat_t        lat_max_o;
  logic        run_done_o;

  int        err_cnt = 0;
  int        chk_cnt = 0;
  int        test_cnt = 0;
  int        edge_cnt = 0;     // Rising edges so far
  int        hs_cnt = 0;       // Handshakes so far
  int        wr_seen = 0;      // Writes in this run
  int        rd_seen = 0;      // Reads in this run
  int        cur_n = 0;
  int        cur_dw = 0;
  dma_addr_t cur_addr = '0;
  bit        rand_ready = 1'b0;
  lat_t      exp_max = '0;     // Largest latency the completer saw
  int        hs_edge [2**TAG_W];
  tag_t      pend_tag [$];     // Reads waiting for completion
  int        pend_due [$];
  logic      rc_next_valid = 1'b0;
  tag_t      rc_next_tag = '0;
  logic      ready_next = 1'b1;  // Ready for the coming cycle
  logic      held = 1'b0;      // Offer stalled at the last edge
  tlp_op_e   held_op;
  dma_addr_t held_addr;
  dw_len_t   held_len;
  tag_t      held_tag;

  `include "tb_bmd_checks.svh"

  bmd_endpoint #(.TAG_W(TAG_W), .TIME_W(TIME_W)) dut (.*);

  always #50 clk = ~clk;  // 100 ns period

  //////////////////////////////
  // Monitor and completer
  //////////////////////////////

  initial begin : monitor
    int   k;
    bit   found;
    lat_t lat;
    void'($urandom(32'h78c8));  // Single seed for ready and completion delays
    forever begin
      @(posedge clk);
      edge_cnt = edge_cnt + 1;
      rc_next_valid = 1'b0;
      ready_next = rand_ready ? ($urandom_range(3, 0) != 0) : 1'b1;  // 75% ready
      if (rst_n) begin
        if (held && !rq_valid_o) begin
          $display("rq_valid_o dropped at t=%0t without a handshake", $time);
          err_cnt++;
        end else if (held) begin  // Stalled offer must not move
          check_req(rq_opcode_o, held_op, rq_addr_o, held_addr, rq_len_o, held_len,
                    rq_tag_o, held_tag, 1'b1);
        end
        if (rq_valid_o && rq_ready_i) begin
          hs_cnt = hs_cnt + 1;
          if (wr_seen < cur_n) begin
            check_req(rq_opcode_o, TLP_MWR,
                      rq_addr_o, ref_req_addr(cur_addr, dw_len_t'(cur_dw), wr_seen),
                      rq_len_o, dw_len_t'(cur_dw), rq_tag_o, '0, 1'b0);
            wr_seen++;
          end else if (rd_seen < cur_n) begin
            check_req(rq_opcode_o, TLP_MRD,
                      rq_addr_o, ref_req_addr(cur_addr, dw_len_t'(cur_dw), rd_seen),
                      rq_len_o, dw_len_t'(cur_dw), rq_tag_o, tag_t'(rd_seen), 1'b1);
            hs_edge[rq_tag_o] = edge_cnt;  // Issue edge of this tag
            pend_tag.push_back(rq_tag_o);
            pend_due.push_back(edge_cnt + int'($urandom_range(20, 1)));
            rd_seen++;
          end else begin
            $display("Request beyond the run length at t=%0t", $time);
            err_cnt++;
          end
        end
        held      = rq_valid_o && !rq_ready_i;
        held_op   = rq_opcode_o;
        held_addr = rq_addr_o;
        held_len  = rq_len_o;
        held_tag  = rq_tag_o;
        // One completion per edge and the first due tag wins
        found = 1'b0;
        k = 0;
        while (!found && k < pend_due.size()) begin
          if (pend_due[k] <= edge_cnt + 1) begin
            found = 1'b1;
            rc_next_valid = 1'b1;
            rc_next_tag = pend_tag[k];
            lat = lat_t'(edge_cnt + 1 - hs_edge[pend_tag[k]]);  // Sampled at the next edge
            if (lat > exp_max) exp_max = lat;
            pend_tag.delete(k);
            pend_due.delete(k);
          end else begin
            k++;
          end
        end
      end
    end
  end

  // Link side inputs change on the falling edge
  always @(negedge clk) begin : driver
    rq_ready_i = ready_next;
    rc_valid_i = rc_next_valid;
    rc_tag_i   = rc_next_tag;
  end

  //////////////////////////////
  // Host side tasks
  //////////////////////////////

  task automatic reg_write(input reg_addr_e a, input reg_data_t d);
    @(negedge clk);
    cq_valid_i = 1'b1;
    cq_write_i = 1'b1;
    cq_addr_i  = a;
    cq_data_i  = d;
    @(negedge clk);
    cq_valid_i = 1'b0;
    cq_write_i = 1'b0;
  endtask

  task automatic reg_read(input reg_addr_e a, output reg_data_t d);
    @(negedge clk);
    cq_valid_i = 1'b1;
    cq_write_i = 1'b0;
    cq_addr_i  = a;
    @(negedge clk);
    cq_valid_i = 1'b0;
    if (!cc_valid_o) begin
      $display("No cc_valid_o one cycle after a read of register %0d at t=%0t", a, $time);
      err_cnt++;
    end
    d = cc_data_o;
    @(negedge clk);
    if (cc_valid_o) begin
      $display("cc_valid_o stayed high a second cycle at t=%0t", $time);
      err_cnt++;
    end
  endtask

  task automatic program_run(input dma_addr_t addr, input int dw, input int n);
    reg_write(REG_DMA_ADDR, addr);
    reg_write(REG_DW_COUNT, reg_data_t'(dw));
    reg_write(REG_TLP_COUNT, reg_data_t'(n));
    cur_addr = addr;
    cur_dw   = dw;
    cur_n    = n;
    wr_seen  = 0;
    rd_seen  = 0;
    exp_max  = '0;
  endtask

  // Init from the start edge must have cleared the statistics
  task automatic start_run();
    @(negedge clk);
    run_start_i = 1'b1;
    repeat (2) @(negedge clk);
    check_reg("cpl_count_o", reg_data_t'(cpl_count_o), '0);
    check_lat("lat_max_o", lat_max_o, '0);
    if (run_done_o) begin
      $display("run_done_o not cleared by the start edge at t=%0t", $time);
      err_cnt++;
    end
    run_start_i = 1'b0;
  endtask

  task automatic finish_run(input int n);
    int        cnt;
    reg_data_t rd;
    cnt = 0;
    while (!run_done_o && cnt < n * 40 + 200) begin
      @(negedge clk);
      cnt++;
    end
    if (!run_done_o) begin
      $display("Run of %0d TLPs did not raise run_done_o within %0d cycles", n, cnt);
      err_cnt++;
    end
    check_reg("cpl_count_o", reg_data_t'(cpl_count_o), reg_data_t'(n));
    check_lat("lat_max_o", lat_max_o, exp_max);
    reg_read(REG_LAT_MAX, rd);
    check_reg("REG_LAT_MAX", rd, exp_max[31:0]);
    reg_read(REG_CPL_COUNT, rd);
    check_reg("REG_CPL_COUNT", rd, reg_data_t'(n));
    if (wr_seen != n || rd_seen != n) begin
      $display("Saw %0d writes and %0d reads, expected %0d of each", wr_seen, rd_seen, n);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    $display("test %s: %s, %0d errors", name,
             (err_cnt == err_before) ? "passed" : "FAILED", err_cnt - err_before);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    reg_data_t rd;
    int        e0;
    int        cnt;
    int        hs_mark;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    e0 = err_cnt;  // Register map
    reg_write(REG_DMA_ADDR, 32'hCAFE_0040);
    reg_write(REG_DW_COUNT, 32'd37);
    reg_write(REG_TLP_COUNT, 32'd21);
    reg_write(reg_addr_e'(3'd6), 32'hFFFF_FFFF);  // Ignored
    reg_read(REG_DMA_ADDR, rd);
    check_reg("REG_DMA_ADDR", rd, 32'hCAFE_0040);
    reg_read(REG_DW_COUNT, rd);
    check_reg("REG_DW_COUNT", rd, 32'd37);
    reg_read(REG_TLP_COUNT, rd);
    check_reg("REG_TLP_COUNT", rd, 32'd21);
    reg_read(reg_addr_e'(3'd6), rd);
    check_reg("unmapped register 6", rd, '0);
    end_test("registers", e0);

    e0 = err_cnt;  // Full ready and plain order
    rand_ready = 1'b0;
    program_run(32'h0001_0000, 4, N_ORDER);
    start_run();
    finish_run(N_ORDER);
    end_test("order_fields", e0);

    e0 = err_cnt;  // Random stalls over all tags
    rand_ready = 1'b1;
    program_run(32'h8000_0F00, 16, N_BP);
    start_run();
    finish_run(N_BP);
    end_test("back_pressure_latency", e0);

    e0 = err_cnt;  // Abort during writes and a clean run after
    program_run(32'h0200_0000, 8, N_ABORT);
    start_run();
    cnt = 0;
    while (wr_seen < 3 && cnt < 200) begin
      @(negedge clk);
      cnt++;
    end
    run_finish_i = 1'b1;
    hs_mark = hs_cnt;
    @(negedge clk);
    run_finish_i = 1'b0;
    repeat (30) @(negedge clk);
    if (hs_cnt - hs_mark > 1 || rd_seen != 0) begin
      $display("Requests went on after run_finish_i: %0d more handshakes, %0d reads",
               hs_cnt - hs_mark, rd_seen);
      err_cnt++;
    end
    if (rq_valid_o) begin
      $display("rq_valid_o still high 30 cycles after run_finish_i");
      err_cnt++;
    end
    program_run(32'h0000_7FF0, 2, N_RESTART);
    start_run();
    finish_run(N_RESTART);
    end_test("finish_restart", e0);

    $display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Bound from the total TLP count of all runs
  initial begin : watchdog
    repeat (WATCHDOG_CYC) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYC);
    $display("Something failed");
    $finish;
  end

endmodule : tb_bmd_endpoint

//--- src.f
+incdir+testbench
verilog/bmd_tlp_pkg.sv
verilog/bmd_ctrl_pkg.sv
verilog/bmd_cmd_if.sv
verilog/bmd_req_decode.sv
verilog/bmd_tx_sequencer.sv
verilog/bmd_cpl_latency.sv
verilog/bmd_endpoint.sv
testbench/tb_bmd_endpoint.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the endpoint testbench with Verilator, status follows the testbench verdict

cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_bmd_endpoint -f src.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
